/* include/adv7513_config.svh */
`ifndef ADV7513_CONFIG_SVH
`define ADV7513_CONFIG_SVH

// 7-bit I2C device address of the transmitter (PD/AD pin low)
`define ADV_CHIP_ADDR 7'h39

// number of register writes in each list
`define ADV_BOOT_STEPS 11
`define ADV_INIT_STEPS 16

// PLL status register and its lock flag
`define ADV_PLL_STATUS_REG 8'h9E
`define ADV_PLL_LOCK_BIT 4

// extra bits for register 0x16
// set 8'h81 for 4:2:2 output with YCbCr black level
`define ADV_OUTPUT_FMT 8'h00

// video register defaults
// 0x17 16:9 aspect, syncs passed through, DE generator off
`define ADV_VID_17_DEFAULT 8'h02
// 0x3B manual pixel repeat, x2 PLL, x1 to receiver
`define ADV_VID_3B_DEFAULT 8'hC8
// 0x3C VIC 16, 1080p60
`define ADV_VID_3C_DEFAULT 8'h10

`endif

/* hdl/adv7513_pkg.sv */
package adv7513_pkg;

    // I2C device address, 7 bits as sent on the bus
    typedef logic [6:0] chip_addr_t;

    // transmitter register map address
    typedef logic [7:0] reg_addr_t;

    // register value, also used for read results
    typedef logic [7:0] reg_data_t;

    // index into the bootstrap or init list
    typedef logic [4:0] step_t;

    // sequencer phase
    typedef enum logic [1:0] {
        phase_boot,
        phase_init,
        phase_pll_check,
        phase_ready
    } init_phase_t;

    // which video register a configuration write targets
    typedef enum logic [1:0] {
        sel_vid_17,
        sel_vid_3b,
        sel_vid_3c
    } cfg_sel_t;

endpackage

/* hdl/adv_video_cfg.sv */
`include "adv7513_config.svh"

module adv_video_cfg (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfg_we,
    input  adv7513_pkg::cfg_sel_t  cfg_sel,
    input  adv7513_pkg::reg_data_t cfg_data,
    input  logic                   cfg_taken,
    output adv7513_pkg::reg_data_t vid_17,
    output adv7513_pkg::reg_data_t vid_3b,
    output adv7513_pkg::reg_data_t vid_3c,
    output logic                   cfg_pending
);

    always_ff @(posedge clk) begin
        if (!reset) begin
            vid_17      <= `ADV_VID_17_DEFAULT;
            vid_3b      <= `ADV_VID_3B_DEFAULT;
            vid_3c      <= `ADV_VID_3C_DEFAULT;
            cfg_pending <= 1'b0;
        end else begin
            if (cfg_we) begin
                case (cfg_sel)
                    adv7513_pkg::sel_vid_17: vid_17 <= cfg_data;
                    adv7513_pkg::sel_vid_3b: vid_3b <= cfg_data;
                    adv7513_pkg::sel_vid_3c: vid_3c <= cfg_data;
                    default: ;
                endcase
            end

            // a new write wins over the sequencer taking the old one
            if (cfg_we) begin
                cfg_pending <= 1'b1;
            end else if (cfg_taken) begin
                cfg_pending <= 1'b0;
            end
        end
    end

endmodule

/* hdl/adv_cmd_rom.sv */
`include "adv7513_config.svh"

module adv_cmd_rom (
    input  adv7513_pkg::init_phase_t phase,
    input  adv7513_pkg::step_t       step,
    input  adv7513_pkg::reg_data_t   vid_17,
    input  adv7513_pkg::reg_data_t   vid_3b,
    input  adv7513_pkg::reg_data_t   vid_3c,
    output adv7513_pkg::reg_addr_t   rom_reg,
    output adv7513_pkg::reg_data_t   rom_value
);

    // {register, value}
    logic [15:0] entry;

    always_comb begin
        entry = 16'h0000;
        case (phase)
            adv7513_pkg::phase_boot: begin
                case (step)
                    // all circuits powered up, sync adjust off
                    5'd0:  entry = {8'h41, 8'h10};
                    // fixed registers from the programming guide
                    5'd1:  entry = {8'h98, 8'h03};
                    5'd2:  entry = {8'h9A, 8'hE0};
                    5'd3:  entry = {8'h9C, 8'h30};
                    5'd4:  entry = {8'h9D, 8'h01};
                    5'd5:  entry = {8'hA2, 8'hA4};
                    5'd6:  entry = {8'hA3, 8'hA4};
                    5'd7:  entry = {8'hE0, 8'hD0};
                    5'd8:  entry = {8'hF9, 8'h00};
                    // enable HPD and monitor sense interrupts
                    5'd9:  entry = {8'h94, 8'hC0};
                    // clear any pending interrupt
                    5'd10: entry = {8'h96, 8'hC0};
                    default: ;
                endcase
            end
            adv7513_pkg::phase_init: begin
                case (step)
                    // 44.1kHz I2S, 24 bit RGB 4:4:4 with separate syncs
                    5'd0:  entry = {8'h15, 8'h00};
                    5'd1:  entry = {8'h17, vid_17};
                    // 8 bit color depth plus output format
                    5'd2:  entry = {8'h16, 8'h30 | `ADV_OUTPUT_FMT};
                    5'd3:  entry = {8'h55, 8'h00};
                    // CSC disabled
                    5'd4:  entry = {8'h18, 8'h46};
                    // HDMI mode, no HDCP
                    5'd5:  entry = {8'hAF, 8'h06};
                    5'd6:  entry = {8'hBA, 8'h60};
                    // automatic CTS, I2S audio, 128xfs
                    5'd7:  entry = {8'h0A, 8'h00};
                    // N = 0x1880 for 44.1kHz
                    5'd8:  entry = {8'h01, 8'h00};
                    5'd9:  entry = {8'h02, 8'h18};
                    5'd10: entry = {8'h03, 8'h80};
                    5'd11: entry = {8'h0B, 8'h0E};
                    // I2S0 on, right justified
                    5'd12: entry = {8'h0C, 8'h05};
                    // 16 bit samples
                    5'd13: entry = {8'h0D, 8'h10};
                    5'd14: entry = {8'h3B, vid_3b};
                    5'd15: entry = {8'h3C, vid_3c};
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign rom_reg   = entry[15:8];
    assign rom_value = entry[7:0];

endmodule

/* hdl/i2c_req_port.sv */
`include "adv7513_config.svh"

module i2c_req_port (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     xfer_start,
    input  adv7513_pkg::reg_addr_t   xfer_reg,
    input  adv7513_pkg::reg_data_t   xfer_wdata,
    input  logic                     xfer_is_read,
    output logic                     xfer_busy,
    output logic                     xfer_done,
    output adv7513_pkg::reg_data_t   xfer_rdata,
    output logic                     xfer_ack_error,
    output logic                     i2c_req,
    output adv7513_pkg::chip_addr_t  i2c_chip_addr,
    output adv7513_pkg::reg_addr_t   i2c_reg_addr,
    output adv7513_pkg::reg_data_t   i2c_wdata,
    output logic                     i2c_is_read,
    input  logic                     i2c_ack,
    input  adv7513_pkg::reg_data_t   i2c_rdata,
    input  logic                     i2c_ack_error
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_release,
        st_done
    } port_state_t;

    port_state_t state;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (xfer_start) state <= st_req;
                // master holds ack as long as it likes
                st_req: if (i2c_ack) state <= st_release;
                st_release: if (!i2c_ack) state <= st_done;
                default: state <= st_idle;
            endcase
        end
    end

    // request fields stay put until req has fallen
    always_ff @(posedge clk) begin
        if (state == st_idle && xfer_start) begin
            i2c_reg_addr <= xfer_reg;
            i2c_wdata    <= xfer_wdata;
            i2c_is_read  <= xfer_is_read;
        end
        if (state == st_req && i2c_ack) begin
            xfer_rdata     <= i2c_rdata;
            xfer_ack_error <= i2c_ack_error;
        end
    end

    assign i2c_chip_addr = `ADV_CHIP_ADDR;
    assign i2c_req       = (state == st_req);
    assign xfer_busy     = (state != st_idle);
    assign xfer_done     = (state == st_done);

endmodule

/* hdl/adv_init_seq.sv */
`include "adv7513_config.svh"

module adv_init_seq (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     hdmi_int,
    input  logic                     cfg_pending,
    input  adv7513_pkg::reg_addr_t   rom_reg,
    input  adv7513_pkg::reg_data_t   rom_value,
    input  logic                     xfer_busy,
    input  logic                     xfer_done,
    input  adv7513_pkg::reg_data_t   xfer_rdata,
    input  logic                     xfer_ack_error,
    output adv7513_pkg::init_phase_t phase,
    output adv7513_pkg::step_t       step,
    output logic                     xfer_start,
    output adv7513_pkg::reg_addr_t   xfer_reg,
    output adv7513_pkg::reg_data_t   xfer_wdata,
    output logic                     xfer_is_read,
    output logic                     cfg_taken,
    output logic                     ready,
    output logic [7:0]               pll_error_count
);

    logic int_sync1;
    logic int_sync2;
    logic int_pending;
    logic last_boot;
    logic last_init;

    assign last_boot = (step == adv7513_pkg::step_t'(`ADV_BOOT_STEPS - 1));
    assign last_init = (step == adv7513_pkg::step_t'(`ADV_INIT_STEPS - 1));

    always_ff @(posedge clk) begin
        if (!reset) begin
            phase           <= adv7513_pkg::phase_boot;
            step            <= '0;
            cfg_taken       <= 1'b0;
            pll_error_count <= 8'd0;
            int_sync1       <= 1'b1;
            int_sync2       <= 1'b1;
            int_pending     <= 1'b0;
        end else begin
            int_sync1 <= hdmi_int;
            int_sync2 <= int_sync1;
            cfg_taken <= 1'b0;

            // boot list ends by clearing the chip interrupt, so anything seen
            // before then is already covered by this pass
            if (phase == adv7513_pkg::phase_boot) begin
                int_pending <= 1'b0;
            end else if (!int_sync2) begin
                int_pending <= 1'b1;
            end

            // on an ack error the step is left alone and goes out again
            if (xfer_done) begin
                if (!xfer_ack_error) begin
                    case (phase)
                        adv7513_pkg::phase_boot: begin
                            if (last_boot) begin
                                phase <= adv7513_pkg::phase_init;
                                step  <= '0;
                            end else begin
                                step <= step + 1'b1;
                            end
                        end
                        adv7513_pkg::phase_init: begin
                            if (last_init) begin
                                phase <= adv7513_pkg::phase_pll_check;
                                step  <= '0;
                            end else begin
                                step <= step + 1'b1;
                            end
                        end
                        adv7513_pkg::phase_pll_check: begin
                            if (xfer_rdata[`ADV_PLL_LOCK_BIT]) begin
                                phase <= adv7513_pkg::phase_ready;
                            end else begin
                                // no lock, run everything again
                                pll_error_count <= pll_error_count + 8'd1;
                                phase           <= adv7513_pkg::phase_boot;
                            end
                        end
                        default: ;
                    endcase
                end
            end

            // hot plug or new video settings while running
            if (phase == adv7513_pkg::phase_ready && (int_pending || cfg_pending)) begin
                phase     <= adv7513_pkg::phase_boot;
                step      <= '0;
                cfg_taken <= 1'b1;
            end
        end
    end

    assign xfer_start   = !xfer_busy && (phase != adv7513_pkg::phase_ready);
    assign xfer_is_read = (phase == adv7513_pkg::phase_pll_check);
    assign xfer_reg     = xfer_is_read ? `ADV_PLL_STATUS_REG : rom_reg;
    assign xfer_wdata   = rom_value;
    assign ready        = (phase == adv7513_pkg::phase_ready);

endmodule

/* hdl/adv7513_ctrl.sv */
module adv7513_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hdmi_int,
    input  logic                    cfg_we,
    input  adv7513_pkg::cfg_sel_t   cfg_sel,
    input  adv7513_pkg::reg_data_t  cfg_data,
    output logic                    i2c_req,
    output adv7513_pkg::chip_addr_t i2c_chip_addr,
    output adv7513_pkg::reg_addr_t  i2c_reg_addr,
    output adv7513_pkg::reg_data_t  i2c_wdata,
    output logic                    i2c_is_read,
    input  logic                    i2c_ack,
    input  adv7513_pkg::reg_data_t  i2c_rdata,
    input  logic                    i2c_ack_error,
    output logic                    ready,
    output logic [7:0]              pll_error_count
);

    adv7513_pkg::reg_data_t   vid_17;
    adv7513_pkg::reg_data_t   vid_3b;
    adv7513_pkg::reg_data_t   vid_3c;
    logic                     cfg_pending;
    logic                     cfg_taken;
    adv7513_pkg::init_phase_t phase;
    adv7513_pkg::step_t       step;
    adv7513_pkg::reg_addr_t   rom_reg;
    adv7513_pkg::reg_data_t   rom_value;
    logic                     xfer_start;
    adv7513_pkg::reg_addr_t   xfer_reg;
    adv7513_pkg::reg_data_t   xfer_wdata;
    logic                     xfer_is_read;
    logic                     xfer_busy;
    logic                     xfer_done;
    adv7513_pkg::reg_data_t   xfer_rdata;
    logic                     xfer_ack_error;

    adv_video_cfg video_cfg0 (
        .clk         (clk),
        .reset       (reset),
        .cfg_we      (cfg_we),
        .cfg_sel     (cfg_sel),
        .cfg_data    (cfg_data),
        .cfg_taken   (cfg_taken),
        .vid_17      (vid_17),
        .vid_3b      (vid_3b),
        .vid_3c      (vid_3c),
        .cfg_pending (cfg_pending)
    );

    adv_cmd_rom cmd_rom0 (
        .phase     (phase),
        .step      (step),
        .vid_17    (vid_17),
        .vid_3b    (vid_3b),
        .vid_3c    (vid_3c),
        .rom_reg   (rom_reg),
        .rom_value (rom_value)
    );

    // one register transaction at a time toward the external I2C master
    i2c_req_port req_port0 (
        .clk            (clk),
        .reset          (reset),
        .xfer_start     (xfer_start),
        .xfer_reg       (xfer_reg),
        .xfer_wdata     (xfer_wdata),
        .xfer_is_read   (xfer_is_read),
        .xfer_busy      (xfer_busy),
        .xfer_done      (xfer_done),
        .xfer_rdata     (xfer_rdata),
        .xfer_ack_error (xfer_ack_error),
        .i2c_req        (i2c_req),
        .i2c_chip_addr  (i2c_chip_addr),
        .i2c_reg_addr   (i2c_reg_addr),
        .i2c_wdata      (i2c_wdata),
        .i2c_is_read    (i2c_is_read),
        .i2c_ack        (i2c_ack),
        .i2c_rdata      (i2c_rdata),
        .i2c_ack_error  (i2c_ack_error)
    );

    adv_init_seq init_seq0 (
        .clk             (clk),
        .reset           (reset),
        .hdmi_int        (hdmi_int),
        .cfg_pending     (cfg_pending),
        .rom_reg         (rom_reg),
        .rom_value       (rom_value),
        .xfer_busy       (xfer_busy),
        .xfer_done       (xfer_done),
        .xfer_rdata      (xfer_rdata),
        .xfer_ack_error  (xfer_ack_error),
        .phase           (phase),
        .step            (step),
        .xfer_start      (xfer_start),
        .xfer_reg        (xfer_reg),
        .xfer_wdata      (xfer_wdata),
        .xfer_is_read    (xfer_is_read),
        .cfg_taken       (cfg_taken),
        .ready           (ready),
        .pll_error_count (pll_error_count)
    );

endmodule

/* sim/i2c_responder.sv */
module i2c_responder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    i2c_req,
    input  adv7513_pkg::chip_addr_t i2c_chip_addr,
    input  adv7513_pkg::reg_addr_t  i2c_reg_addr,
    input  adv7513_pkg::reg_data_t  i2c_wdata,
    input  logic                    i2c_is_read,
    output logic                    i2c_ack,
    output adv7513_pkg::reg_data_t  i2c_rdata,
    output logic                    i2c_ack_error
);

    // {chip address, read flag, register, write data}, write data is zero on reads
    logic [23:0] log_q[$];
    // log index that gets an ack error, -1 for none
    int          err_at = -1;
    // PLL reads still to be answered without lock
    int          pll_fail_left = 0;
    // upper bound of the random ack and release delays
    int          max_delay = 0;
    int          field_changes = 0;
    int          seed = 84866;
    logic        req_q;
    logic [23:0] fields_q;
    logic [23:0] entry;

    task automatic hold_random();
        int n;
        n = 0;
        if (max_delay > 0) begin
            n = $unsigned($random(seed)) % (max_delay + 1);
        end
        repeat (n) @(posedge clk);
    endtask

    initial begin
        i2c_ack       = 1'b0;
        i2c_rdata     = 8'h00;
        i2c_ack_error = 1'b0;
        forever begin
            @(posedge clk);
            if (reset && i2c_req && !i2c_ack) begin
                entry = {i2c_chip_addr, i2c_is_read, i2c_reg_addr,
                         i2c_is_read ? 8'h00 : i2c_wdata};
                hold_random();
                i2c_ack_error <= (log_q.size() == err_at);
                // bit 4 is the PLL lock flag, the other bits are noise
                if (entry[16] && pll_fail_left > 0) begin
                    i2c_rdata <= 8'h6F;
                    pll_fail_left--;
                end else begin
                    i2c_rdata <= 8'h70;
                end
                log_q.push_back(entry);
                i2c_ack <= 1'b1;
                do @(posedge clk); while (i2c_req);
                hold_random();
                i2c_ack <= 1'b0;
            end
        end
    end

    // request fields must hold while req is high
    always @(posedge clk) begin
        if (i2c_req && req_q &&
            {i2c_chip_addr, i2c_is_read, i2c_reg_addr, i2c_wdata} != fields_q) begin
            field_changes <= field_changes + 1;
        end
        req_q    <= i2c_req;
        fields_q <= {i2c_chip_addr, i2c_is_read, i2c_reg_addr, i2c_wdata};
    end

endmodule

/* sim/tb_adv7513_ctrl.sv */
`include "adv7513_config.svh"

module tb_adv7513_ctrl;

    localparam int clk_period    = 10;
    localparam int max_delay_cfg = 6;
    // worst case cycles of one transaction, and of one pass with a retried step
    localparam int xfer_cycles   = 2 * max_delay_cfg + 10;
    localparam int seq_cycles    = (`ADV_BOOT_STEPS + `ADV_INIT_STEPS + 2) * xfer_cycles;
    localparam int watchdog_time = 6 * seq_cycles * clk_period;

    logic                    clk;
    logic                    reset;
    logic                    hdmi_int;
    logic                    cfg_we;
    adv7513_pkg::cfg_sel_t   cfg_sel;
    adv7513_pkg::reg_data_t  cfg_data;
    logic                    i2c_req;
    adv7513_pkg::chip_addr_t i2c_chip_addr;
    adv7513_pkg::reg_addr_t  i2c_reg_addr;
    adv7513_pkg::reg_data_t  i2c_wdata;
    logic                    i2c_is_read;
    logic                    i2c_ack;
    adv7513_pkg::reg_data_t  i2c_rdata;
    logic                    i2c_ack_error;
    logic                    ready;
    logic [7:0]              pll_error_count;

    logic [23:0] exp_q[$];
    int          dup_at = -1;
    int          mismatch_count = 0;
    int          fail_count = 0;

    adv7513_ctrl dut0 (
        .clk             (clk),
        .reset           (reset),
        .hdmi_int        (hdmi_int),
        .cfg_we          (cfg_we),
        .cfg_sel         (cfg_sel),
        .cfg_data        (cfg_data),
        .i2c_req         (i2c_req),
        .i2c_chip_addr   (i2c_chip_addr),
        .i2c_reg_addr    (i2c_reg_addr),
        .i2c_wdata       (i2c_wdata),
        .i2c_is_read     (i2c_is_read),
        .i2c_ack         (i2c_ack),
        .i2c_rdata       (i2c_rdata),
        .i2c_ack_error   (i2c_ack_error),
        .ready           (ready),
        .pll_error_count (pll_error_count)
    );

    i2c_responder resp0 (
        .clk           (clk),
        .reset         (reset),
        .i2c_req       (i2c_req),
        .i2c_chip_addr (i2c_chip_addr),
        .i2c_reg_addr  (i2c_reg_addr),
        .i2c_wdata     (i2c_wdata),
        .i2c_is_read   (i2c_is_read),
        .i2c_ack       (i2c_ack),
        .i2c_rdata     (i2c_rdata),
        .i2c_ack_error (i2c_ack_error)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // bootstrap list {register, value}
    function automatic logic [15:0] boot_write(input int i);
        case (i)
            0:       return 16'h4110;
            1:       return 16'h9803;
            2:       return 16'h9AE0;
            3:       return 16'h9C30;
            4:       return 16'h9D01;
            5:       return 16'hA2A4;
            6:       return 16'hA3A4;
            7:       return 16'hE0D0;
            8:       return 16'hF900;
            9:       return 16'h94C0;
            10:      return 16'h96C0;
            default: return 16'h0000;
        endcase
    endfunction

    // video and audio init list
    function automatic logic [15:0] init_write(input int i, input logic [7:0] v17,
                                               input logic [7:0] v3b, input logic [7:0] v3c);
        case (i)
            0:       return 16'h1500;
            1:       return {8'h17, v17};
            2:       return {8'h16, 8'h30 | `ADV_OUTPUT_FMT};
            3:       return 16'h5500;
            4:       return 16'h1846;
            5:       return 16'hAF06;
            6:       return 16'hBA60;
            7:       return 16'h0A00;
            8:       return 16'h0100;
            9:       return 16'h0218;
            10:      return 16'h0380;
            11:      return 16'h0B0E;
            12:      return 16'h0C05;
            13:      return 16'h0D10;
            14:      return {8'h3B, v3b};
            15:      return {8'h3C, v3c};
            default: return 16'h0000;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            mismatch_count++;
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // an entry at index dup_at is expected twice, as after an ack error
    task automatic push_expected(input logic [16:0] item);
        exp_q.push_back({`ADV_CHIP_ADDR, item});
        if (exp_q.size() - 1 == dup_at) begin
            exp_q.push_back({`ADV_CHIP_ADDR, item});
        end
    endtask

    task automatic add_sequence(input logic [7:0] v17, input logic [7:0] v3b,
                                input logic [7:0] v3c);
        int i;
        for (i = 0; i < `ADV_BOOT_STEPS; i++) begin
            push_expected({1'b0, boot_write(i)});
        end
        for (i = 0; i < `ADV_INIT_STEPS; i++) begin
            push_expected({1'b0, init_write(i, v17, v3b, v3c)});
        end
        push_expected({1'b1, `ADV_PLL_STATUS_REG, 8'h00});
    endtask

    task automatic clear_logs(input int dup);
        resp0.log_q.delete();
        exp_q.delete();
        dup_at = dup;
    endtask

    task automatic compare_log(input string name);
        int i;
        int n;
        check_value({name, " transaction count"}, resp0.log_q.size(), exp_q.size());
        n = (resp0.log_q.size() < exp_q.size()) ? resp0.log_q.size() : exp_q.size();
        for (i = 0; i < n; i++) begin
            check_value($sformatf("%s transaction %0d", name, i), resp0.log_q[i], exp_q[i]);
        end
    endtask

    task automatic wait_ready_level(input logic level, input int limit, input string name);
        int n;
        n = 0;
        while (ready !== level && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (ready !== level) begin
            fail_count++;
            $display("%s: ready did not go to %0d within %0d cycles", name, level, limit);
        end
    endtask

    task automatic apply_reset(input int err_at, input int pll_fails, input int max_delay);
        @(posedge clk);
        reset <= 1'b0;
        resp0.err_at        = err_at;
        resp0.pll_fail_left = pll_fails;
        resp0.max_delay     = max_delay;
        repeat (5) @(posedge clk);
        check_value("i2c_req in reset", i2c_req, 0);
        check_value("ready in reset", ready, 0);
        check_value("pll_error_count in reset", pll_error_count, 0);
        reset <= 1'b1;
    endtask

    task automatic power_up_sequence();
        int n;
        clear_logs(-1);
        apply_reset(-1, 0, 0);
        add_sequence(`ADV_VID_17_DEFAULT, `ADV_VID_3B_DEFAULT, `ADV_VID_3C_DEFAULT);
        n = 0;
        while (!i2c_req && n < 8) begin
            @(posedge clk);
            n++;
        end
        if (!i2c_req) begin
            fail_count++;
            $display("power-up: no I2C request within 8 cycles after reset");
        end
        wait_ready_level(1'b1, seq_cycles, "power-up");
        compare_log("power-up");
        check_value("power-up pll_error_count", pll_error_count, 0);
    endtask

    task automatic hot_plug_restart();
        clear_logs(-1);
        add_sequence(`ADV_VID_17_DEFAULT, `ADV_VID_3B_DEFAULT, `ADV_VID_3C_DEFAULT);
        @(posedge clk);
        hdmi_int <= 1'b0;
        repeat (4) @(posedge clk);
        hdmi_int <= 1'b1;
        wait_ready_level(1'b0, 20, "hot plug");
        wait_ready_level(1'b1, seq_cycles, "hot plug");
        compare_log("hot plug");
    endtask

    task automatic video_reconfig();
        clear_logs(-1);
        // VIC 4, 720p60
        add_sequence(`ADV_VID_17_DEFAULT, `ADV_VID_3B_DEFAULT, 8'h04);
        @(posedge clk);
        cfg_we   <= 1'b1;
        cfg_sel  <= adv7513_pkg::sel_vid_3c;
        cfg_data <= 8'h04;
        @(posedge clk);
        cfg_we   <= 1'b0;
        wait_ready_level(1'b0, 20, "reconfig");
        wait_ready_level(1'b1, seq_cycles, "reconfig");
        compare_log("reconfig");
    endtask

    task automatic ack_error_retry();
        // transaction 13 is the write to register 0x16
        clear_logs(13);
        apply_reset(13, 0, 0);
        add_sequence(`ADV_VID_17_DEFAULT, `ADV_VID_3B_DEFAULT, `ADV_VID_3C_DEFAULT);
        wait_ready_level(1'b1, seq_cycles, "ack error");
        compare_log("ack error");
        check_value("ack error pll_error_count", pll_error_count, 0);
    endtask

    task automatic pll_lock_retry();
        clear_logs(-1);
        apply_reset(-1, 1, 0);
        add_sequence(`ADV_VID_17_DEFAULT, `ADV_VID_3B_DEFAULT, `ADV_VID_3C_DEFAULT);
        add_sequence(`ADV_VID_17_DEFAULT, `ADV_VID_3B_DEFAULT, `ADV_VID_3C_DEFAULT);
        wait_ready_level(1'b1, 2 * seq_cycles, "pll retry");
        compare_log("pll retry");
        check_value("pll retry pll_error_count", pll_error_count, 1);
    endtask

    task automatic ack_back_pressure();
        clear_logs(-1);
        apply_reset(-1, 0, max_delay_cfg);
        add_sequence(`ADV_VID_17_DEFAULT, `ADV_VID_3B_DEFAULT, `ADV_VID_3C_DEFAULT);
        wait_ready_level(1'b1, seq_cycles, "back-pressure");
        compare_log("back-pressure");
        check_value("request field changes while req high", resp0.field_changes, 0);
    endtask

    initial begin
        reset    = 1'b0;
        hdmi_int = 1'b1;
        cfg_we   = 1'b0;
        cfg_sel  = adv7513_pkg::sel_vid_17;
        cfg_data = 8'h00;
        power_up_sequence();
        hot_plug_restart();
        video_reconfig();
        ack_error_retry();
        pll_lock_retry();
        ack_back_pressure();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("watchdog expired after %0d time units, the tests did not finish", watchdog_time);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
hdl/adv7513_pkg.sv
hdl/adv_video_cfg.sv
hdl/adv_cmd_rom.sv
hdl/i2c_req_port.sv
hdl/adv_init_seq.sv
hdl/adv7513_ctrl.sv
sim/i2c_responder.sv
sim/tb_adv7513_ctrl.sv

/* Bender.yml */
package:
  name: adv7513_ctrl

export_include_dirs:
  - include

sources:
  - hdl/adv7513_pkg.sv
  - hdl/adv_video_cfg.sv
  - hdl/adv_cmd_rom.sv
  - hdl/i2c_req_port.sv
  - hdl/adv_init_seq.sv
  - hdl/adv7513_ctrl.sv
  - target: simulation
    files:
      - sim/i2c_responder.sv
      - sim/tb_adv7513_ctrl.sv
